// ==== files.f ====
+incdir+source
source/fetch_pkg.sv
source/pc_fetch_unit.sv
source/imem_axi_rd.sv
source/fetch_top.sv
dv/fetch_monitor.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

   localparam int load_cycles  = 1 << `IMEM_WORDS_LOG2;
   // preload runs inside reset, then 10 quiet reset cycles
   localparam int rst_cycles   = load_cycles + 10;
   localparam int window_insts = load_cycles * 2;
   // accepted instructions per test
   localparam int n_seq   = 40;
   localparam int n_stall = 40;
   localparam int n_redir = 60;
   localparam int n_oor   = 16;
   localparam int n_mix   = 200;
   localparam int n_total = n_seq + n_stall + n_redir + n_oor + n_mix;
   localparam int cycle_limit = n_total * (`IMEM_MAX_LAT + 4) * 4 + rst_cycles;

   logic                        clk;
   logic                        rst;
   logic [`XLEN-1:0]            dnpc;
   logic                        pc_update;
   logic [31:0]                 inst;
   logic [`XLEN-1:0]            inst_pc;
   logic                        inst_err;
   logic                        inst_valid;
   logic                        inst_ready;
   logic                        load_en;
   logic [`IMEM_WORDS_LOG2-1:0] load_addr;
   logic [`BUS_DW-1:0]          load_data;

   int accept_count;
   int err_inst_count;
   int mon_errors;
   int seed        = 32'hd67;
   int cycles      = 0;
   int tb_errors   = 0;
   int accept_goal = 0;
   int tests_run   = 0;
   int all_errors;

   fetch_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .dnpc       (dnpc),
      .pc_update  (pc_update),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_err   (inst_err),
      .inst_valid (inst_valid),
      .inst_ready (inst_ready),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data)
   );

   fetch_monitor u_mon (
      .clk            (clk),
      .rst            (rst),
      .dnpc           (dnpc),
      .pc_update      (pc_update),
      .inst           (inst),
      .inst_pc        (inst_pc),
      .inst_err       (inst_err),
      .inst_valid     (inst_valid),
      .inst_ready     (inst_ready),
      .load_en        (load_en),
      .load_addr      (load_addr),
      .load_data      (load_data),
      .accept_count   (accept_count),
      .err_inst_count (err_inst_count),
      .error_count    (mon_errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("run timed out after %0d cycles, instructions stopped arriving", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic int errors_so_far();
      return mon_errors + tb_errors + u_dut.u_ifu.u_chk.fail_count;
   endfunction

   // word-aligned jump target that leaves the window only when the draw says so
   function automatic logic [`XLEN-1:0] pick_target(input int oor_pct);
      logic [`XLEN-1:0] base;
      if (($unsigned($random(seed)) % 100) < oor_pct) begin
         base = 64'h0000_0000_9000_0000;
      end else begin
         base = `IMEM_BASE;
      end
      return base + 64'(($unsigned($random(seed)) % window_insts) * 4);
   endfunction

   // single redirect pulse with decode held off
   task automatic redirect_to(input logic [`XLEN-1:0] target_pc);
      inst_ready = 1'b0;
      dnpc       = target_pc;
      pc_update  = 1'b1;
      @(posedge clk);
      #1;
      pc_update = 1'b0;
   endtask

   // runs until n more instructions are accepted
   // exp_errs below zero leaves the error-fetch count unchecked
   task automatic run_test(input string name, input int n, input int ready_pct,
                           input int redir_pct, input int oor_pct, input int exp_errs);
      int errs_before;
      int err_insts_before;
      errs_before      = errors_so_far();
      err_insts_before = err_inst_count;
      accept_goal      = accept_goal + n;
      @(posedge clk);
      #1;
      while (accept_count < accept_goal) begin
         inst_ready = (($unsigned($random(seed)) % 100) < ready_pct);
         pc_update  = 1'b0;
         if (($unsigned($random(seed)) % 100) < redir_pct) begin
            pc_update = 1'b1;
            dnpc      = pick_target(oor_pct);
         end
         @(posedge clk);
         #1;
      end
      inst_ready = 1'b0;
      pc_update  = 1'b0;
      if (exp_errs >= 0 && err_inst_count - err_insts_before != exp_errs) begin
         tb_errors++;
         $display("[ERROR] %0t: %0d fetches with inst_err, expected %0d",
                  $time, err_inst_count - err_insts_before, exp_errs);
      end
      tests_run++;
      $display("test %-14s %4d instructions, %0d errors",
               name, n, errors_so_far() - errs_before);
   endtask

   initial begin
      rst        = 1'b1;
      dnpc       = '0;
      pc_update  = 1'b0;
      inst_ready = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      // one word per cycle through the load port
      for (int i = 0; i < load_cycles; i++) begin
         @(posedge clk);
         #1;
         load_en   = 1'b1;
         load_addr = (`IMEM_WORDS_LOG2)'(i);
         load_data = {$random(seed), $random(seed)};
      end
      @(posedge clk);
      #1;
      load_en = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      run_test("sequential", n_seq, 100, 0, 0, -1);
      run_test("stalls", n_stall, 70, 0, 0, -1);
      run_test("redirects", n_redir, 70, 5, 0, -1);
      // outside the window every fetch errors until the jump back
      redirect_to(64'h0000_0000_9000_0100);
      run_test("out_of_range", n_oor / 2, 100, 0, 0, n_oor / 2);
      redirect_to(`RESET_PC + 64'h40);
      run_test("back_in_range", n_oor / 2, 100, 0, 0, 0);
      run_test("random_mix", n_mix, 70, 5, 25, -1);

      all_errors = errors_so_far();
      $display("%0d tests, %0d instructions accepted, %0d errors",
               tests_run, accept_count, all_errors);
      if (all_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== dv/fetch_checker.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_checker (
   input logic               clk,
   input logic               rst,
   input logic               arvalid,
   input logic [`BUS_AW-1:0] araddr,
   input logic               arready,
   input logic               rvalid,
   input logic               rready,
   input logic               inst_valid
);

   // failed assertions, picked up by the testbench verdict
   int   fail_count = 0;
   // read open from AR transfer to R transfer
   logic outstanding;

   always @(posedge clk) begin
      if (rst) begin
         outstanding <= 1'b0;
      end else if (arvalid && arready) begin
         outstanding <= 1'b1;
      end else if (rvalid && rready) begin
         outstanding <= 1'b0;
      end
   end

   // request held until the slave takes it
   ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else begin
         fail_count++;
         $error("AR request changed before arready");
      end

   rready_open: assert property (@(posedge clk) disable iff (rst)
      rready |-> outstanding)
      else begin
         fail_count++;
         $error("rready high with no read outstanding");
      end

   // new instruction only from an R beat one cycle earlier
   valid_from_r: assert property (@(posedge clk) disable iff (rst)
      $rose(inst_valid) |-> $past(rvalid && rready))
      else begin
         fail_count++;
         $error("inst_valid rose without an R transfer");
      end

   reset_quiet: assert property (@(posedge clk)
      rst |=> !arvalid && !rready && !inst_valid)
      else begin
         fail_count++;
         $error("handshake outputs active after reset");
      end

endmodule

bind pc_fetch_unit fetch_checker u_chk (
   .clk        (clk),
   .rst        (rst),
   .arvalid    (arvalid),
   .araddr     (araddr),
   .arready    (arready),
   .rvalid     (rvalid),
   .rready     (rready),
   .inst_valid (inst_valid)
);

// ==== dv/fetch_monitor.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_monitor
   import fetch_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`XLEN-1:0]            dnpc,
   input  logic                        pc_update,
   input  logic [31:0]                 inst,
   input  logic [`XLEN-1:0]            inst_pc,
   input  logic                        inst_err,
   input  logic                        inst_valid,
   input  logic                        inst_ready,
   input  logic                        load_en,
   input  logic [`IMEM_WORDS_LOG2-1:0] load_addr,
   input  logic [`BUS_DW-1:0]          load_data,
   output int                          accept_count,
   output int                          err_inst_count,
   output int                          error_count
);

   // byte window of the instruction memory
   localparam logic [`XLEN-1:0] win_lo = `IMEM_BASE;
   localparam logic [`XLEN-1:0] win_hi = win_lo + ((1 << `IMEM_WORDS_LOG2) * 8);

   // shadow of the preloaded words
   logic [`BUS_DW-1:0] model_mem [1 << `IMEM_WORDS_LOG2];
   // pc the next accepted instruction must carry
   logic [`XLEN-1:0]   exp_pc;
   logic [`XLEN-1:0]   next_pc;
   bus_resp_t          exp_resp;
   logic [31:0]        exp_inst;
   logic [`BUS_DW-1:0] exp_word;
   int                 errs;

   // last stalled beat, must still be there next edge
   logic               stall_seen;
   logic [31:0]        stall_inst;
   logic [`XLEN-1:0]   stall_pc;
   logic               stall_err;

   function automatic logic pc_in_window(input logic [`XLEN-1:0] pc);
      return (pc >= win_lo) && (pc < win_hi);
   endfunction

   // mirror of the load port
   always @(posedge clk) begin
      if (load_en) begin
         model_mem[load_addr] <= load_data;
      end
   end

   always @(posedge clk) begin
      if (rst) begin
         exp_pc         <= `RESET_PC;
         stall_seen     <= 1'b0;
         accept_count   <= 0;
         err_inst_count <= 0;
         error_count    <= 0;
      end else begin
         errs    = 0;
         next_pc = exp_pc;
         // held beat while decode stalls, no redirect in between
         if (stall_seen) begin
            if (!inst_valid) begin
               $display("[ERROR] %0t: inst_valid dropped while decode stalled", $time);
               errs++;
            end else if (inst !== stall_inst || inst_pc !== stall_pc ||
                         inst_err !== stall_err) begin
               $display("[ERROR] %0t: output changed while stalled, pc %h", $time, inst_pc);
               errs++;
            end
         end
         if (inst_valid && inst_ready) begin
            exp_resp = pc_in_window(exp_pc) ? resp_okay : resp_slverr;
            exp_word = model_mem[exp_pc[`IMEM_WORDS_LOG2+2:3]];
            if (exp_resp == resp_slverr) begin
               exp_inst = 32'h0;
            end else begin
               // upper half of the beat for pc bit 2 set
               exp_inst = exp_pc[2] ? exp_word[63:32] : exp_word[31:0];
            end
            if (inst_pc !== exp_pc) begin
               $display("[ERROR] %0t: pc %h, expected %h", $time, inst_pc, exp_pc);
               errs++;
            end
            if (inst_err !== (exp_resp == resp_slverr)) begin
               $display("[ERROR] %0t: inst_err %b at pc %h", $time, inst_err, exp_pc);
               errs++;
            end
            if (inst !== exp_inst) begin
               $display("[ERROR] %0t: inst %h, expected %h at pc %h",
                        $time, inst, exp_inst, exp_pc);
               errs++;
            end
            accept_count <= accept_count + 1;
            if (inst_err) begin
               err_inst_count <= err_inst_count + 1;
            end
            next_pc = exp_pc + 4;
         end
         // accept first, then the redirect decides the next pc
         if (pc_update) begin
            next_pc = dnpc;
         end
         exp_pc      <= next_pc;
         error_count <= error_count + errs;
         stall_seen  <= inst_valid && !inst_ready && !pc_update;
         stall_inst  <= inst;
         stall_pc    <= inst_pc;
         stall_err   <= inst_err;
      end
   end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top
   import fetch_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   // redirect from execute
   input  logic [`XLEN-1:0]            dnpc,
   input  logic                        pc_update,
   // instruction toward decode
   output logic [31:0]                 inst,
   output logic [`XLEN-1:0]            inst_pc,
   output logic                        inst_err,
   output logic                        inst_valid,
   input  logic                        inst_ready,
   // memory preload, only while in reset
   input  logic                        load_en,
   input  logic [`IMEM_WORDS_LOG2-1:0] load_addr,
   input  logic [`BUS_DW-1:0]          load_data
);

   // AR channel
   logic               arvalid;
   logic [`BUS_AW-1:0] araddr;
   logic               arready;
   // R channel
   logic               rvalid;
   logic [`BUS_DW-1:0] rdata;
   bus_resp_t          rresp;
   logic               rready;

   // fetch unit, bus master
   pc_fetch_unit u_ifu (
      .clk        (clk),
      .rst        (rst),
      .dnpc       (dnpc),
      .pc_update  (pc_update),
      .arvalid    (arvalid),
      .araddr     (araddr),
      .arready    (arready),
      .rvalid     (rvalid),
      .rdata      (rdata),
      .rresp      (rresp),
      .rready     (rready),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_err   (inst_err),
      .inst_valid (inst_valid),
      .inst_ready (inst_ready)
   );

   // instruction memory, read slave
   imem_axi_rd u_imem (
      .clk       (clk),
      .rst       (rst),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arready   (arready),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .rready    (rready),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

// ==== source/imem_axi_rd.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module imem_axi_rd
   import fetch_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   // AR channel
   input  logic                        arvalid,
   input  logic [`BUS_AW-1:0]          araddr,
   output logic                        arready,
   // R channel
   output logic                        rvalid,
   output logic [`BUS_DW-1:0]          rdata,
   output bus_resp_t                   rresp,
   input  logic                        rready,
   // preload port, word addressed
   input  logic                        load_en,
   input  logic [`IMEM_WORDS_LOG2-1:0] load_addr,
   input  logic [`BUS_DW-1:0]          load_data
);

   localparam int unsigned depth = 1 << `IMEM_WORDS_LOG2;
   localparam int unsigned lat_w = $clog2(`IMEM_MAX_LAT);

   // window bounds one bit wider so the top cannot wrap
   localparam logic [`BUS_AW:0] win_lo = {1'b0, `IMEM_BASE};
   localparam logic [`BUS_AW:0] win_hi = win_lo + (depth << 3);

   logic [`BUS_DW-1:0] mem [depth];

   // latency source, free running
   logic [7:0]                  lfsr;
   // a read is open from AR transfer to R transfer
   logic                        busy;
   logic [lat_w-1:0]            lat_cnt;
   logic [`IMEM_WORDS_LOG2-1:0] rd_idx;
   logic                        rd_err;

   logic                        in_range;
   logic                        ar_fire;
   logic                        r_fire;
   logic                        lat_done;

   // single outstanding read
   assign arready = !busy;

   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid && rready;

   assign in_range = ({1'b0, araddr} >= win_lo) && ({1'b0, araddr} < win_hi);

   // countdown expired, beat goes out next edge
   assign lat_done = busy && !rvalid && (lat_cnt == '0);

   // preload from the testbench
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // x^8 + x^6 + x^5 + x^4 + 1, maximal length
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= 8'ha5;
      end else begin
         lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy   <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         // AR and R cannot fire together, busy keeps them apart
         if (ar_fire) begin
            busy <= 1'b1;
         end else if (r_fire) begin
            busy <= 1'b0;
         end
         // rvalid holds until the master takes the beat
         if (r_fire) begin
            rvalid <= 1'b0;
         end else if (lat_done) begin
            rvalid <= 1'b1;
         end
      end
   end

   // request capture and latency countdown
   // count of n gives rvalid n+1 cycles after the AR transfer
   always_ff @(posedge clk) begin
      if (ar_fire) begin
         lat_cnt <= lfsr[lat_w-1:0];
         rd_idx  <= araddr[`IMEM_WORDS_LOG2+2:3];
         rd_err  <= !in_range;
      end else if (busy && !rvalid && lat_cnt != '0) begin
         lat_cnt <= lat_cnt - 1'b1;
      end
   end

   // response beat, stable while rvalid is high
   always_ff @(posedge clk) begin
      if (lat_done) begin
         rdata <= rd_err ? '0 : mem[rd_idx];
         rresp <= rd_err ? resp_slverr : resp_okay;
      end
   end

endmodule

// ==== source/pc_fetch_unit.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pc_fetch_unit
   import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // redirect from execute, one-cycle pulse
   input  logic [`XLEN-1:0]  dnpc,
   input  logic              pc_update,
   // AR channel
   output logic              arvalid,
   output logic [`BUS_AW-1:0] araddr,
   input  logic              arready,
   // R channel
   input  logic              rvalid,
   input  logic [`BUS_DW-1:0] rdata,
   input  bus_resp_t         rresp,
   output logic              rready,
   // toward decode
   output logic [31:0]       inst,
   output logic [`XLEN-1:0]  inst_pc,
   output logic              inst_err,
   output logic              inst_valid,
   input  logic              inst_ready
);

   // one RV instruction per fetch, no compressed support
   localparam logic [`XLEN-1:0] pc_step = 'd4;

   fetch_state_t state;
   fetch_state_t state_next;

   logic [`XLEN-1:0]   pc;
   logic [`XLEN-1:0]   pc_next;
   // redirect seen while a read was in flight
   logic               drop;
   // address held for the whole AR phase
   logic [`BUS_AW-1:0] ar_addr;

   logic               ar_fire;
   logic               r_fire;
   logic               accept;
   logic               keep_r;
   logic [31:0]        r_word;

   // bus and output strobes come straight from the state
   assign arvalid    = (state == st_addr);
   assign rready     = (state == st_data);
   assign inst_valid = (state == st_hold);
   assign araddr     = ar_addr;

   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid && rready;
   assign accept  = inst_valid && inst_ready;

   // R beat is stale if a redirect came earlier or lands on the same edge
   assign keep_r = r_fire && !drop && !pc_update;

   // 64-bit beat carries two instructions, pc bit 2 picks one
   assign r_word = pc[2] ? rdata[`BUS_DW-1:32] : rdata[31:0];

   // next pc
   // redirect wins over the +4 step, the accepted one still counts
   always_comb begin
      pc_next = pc;
      if (pc_update) begin
         pc_next = dnpc;
      end else if (accept) begin
         pc_next = pc + pc_step;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         // first request right after reset
         st_idle: state_next = st_addr;
         st_addr: begin
            if (ar_fire) begin
               state_next = st_data;
            end
         end
         st_data: begin
            // stale beat is swallowed and the new pc is requested
            if (r_fire) begin
               state_next = keep_r ? st_hold : st_addr;
            end
         end
         st_hold: begin
            // redirect withdraws the buffered instruction
            if (accept || pc_update) begin
               state_next = st_addr;
            end
         end
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         pc    <= `RESET_PC;
         drop  <= 1'b0;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         // AXI cannot cancel a read, so remember to discard its beat
         if (r_fire) begin
            drop <= 1'b0;
         end else if (pc_update && (state == st_addr || state == st_data)) begin
            drop <= 1'b1;
         end
      end
   end

   // araddr is captured on entry to addr and frozen until the AR transfer
   always_ff @(posedge clk) begin
      if (state_next == st_addr && state != st_addr) begin
         ar_addr <= {pc_next[`BUS_AW-1:3], 3'b000};
      end
   end

   // output buffer
   // pc still matches the request here, any redirect would have set keep_r low
   always_ff @(posedge clk) begin
      if (keep_r) begin
         inst_pc  <= pc;
         inst_err <= (rresp == resp_slverr);
         // bus error delivers a zero word
         inst     <= (rresp == resp_slverr) ? 32'h0 : r_word;
      end
   end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

   // fetch unit FSM
   // idle  only after reset, one cycle
   // addr  AR request pending on the bus
   // data  AR taken, waiting for the R beat
   // hold  instruction buffered for decode
   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_addr = 2'd1,
      st_data = 2'd2,
      st_hold = 2'd3
   } fetch_state_t;

   // read response code on rresp
   // only the two codes a plain memory can return
   typedef enum logic {
      resp_okay   = 1'b0,
      resp_slverr = 1'b1
   } bus_resp_t;

endpackage

// ==== source/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// core register width, pc and redirect target
`define XLEN 64

// instruction read bus
`define BUS_DW 64
`define BUS_AW 32

// first pc after reset
`define RESET_PC 64'h0000_0000_8000_0000

// memory window starts at the reset pc
`define IMEM_BASE 32'h8000_0000
// 64 words of 8 bytes, 512 bytes in total
`define IMEM_WORDS_LOG2 6

// read latency 1..IMEM_MAX_LAT, kept a power of two
`define IMEM_MAX_LAT 4

`endif
